// ==== source/discrete_audio_pkg.sv ====
/*
 * Discrete audio board shared definitions.
 * Sample and coefficient types, fixed-point widths, the filter sequencer
 * states and the RC coefficient and saturation helpers.
 */
package discrete_audio_pkg;

    localparam int SAMPLE_WIDTH = 16;
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    localparam sample_t SAMPLE_MAX = sample_t'(2 ** (SAMPLE_WIDTH - 1) - 1);
    localparam sample_t SAMPLE_MIN = sample_t'(-(2 ** (SAMPLE_WIDTH - 1)));

    // unsigned fraction, one extra integer bit so 1.0 fits
    localparam int COEF_FRAC_BITS = 16;
    typedef logic [COEF_FRAC_BITS:0] coef_t;

    // 256 is unity gain
    localparam int GAIN_FRAC_BITS = 8;

    typedef enum logic {
        FILTER_IDLE,
        FILTER_STEP
    } filter_state_t;

    localparam longint PICO_SCALE = 64'sd1_000_000_000_000;

    // alpha = dt / (RC + dt) with dt = 1 / (sample_rate * oversample), C in pF
    function automatic coef_t rc_alpha(
        input longint r,
        input longint c_pf,
        input longint sample_rate,
        input longint oversample
    );
        longint numer;
        longint denom;
        numer = (longint'(1) <<< COEF_FRAC_BITS) * PICO_SCALE;
        denom = PICO_SCALE + r * c_pf * sample_rate * oversample;
        return coef_t'(numer / denom);
    endfunction

    // clamp a wide signed value into the sample range
    function automatic sample_t saturate_sample(input logic signed [63:0] value);
        if (value > SAMPLE_MAX) begin
            return SAMPLE_MAX;
        end else if (value < SAMPLE_MIN) begin
            return SAMPLE_MIN;
        end
        return sample_t'(value);
    endfunction

endpackage

// ==== source/sample_rate_enable.sv ====
/*
 * Audio sample strobe generator.
 * Divides the system clock down to a one-cycle enable at the sample rate.
 */
`timescale 1ns/100ps

module sample_rate_enable #(
    parameter int CLOCK_RATE  = 50000000,
    parameter int SAMPLE_RATE = 48000
) (
    input  logic clk,
    input  logic reset,
    output logic audio_clk_en
);

    localparam int DIVISOR     = CLOCK_RATE / SAMPLE_RATE;
    localparam int COUNT_WIDTH = $clog2(DIVISOR);

    logic [COUNT_WIDTH-1:0] count;

    // down-counter, strobe fires on the reload cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            count        <= COUNT_WIDTH'(DIVISOR - 1);
            audio_clk_en <= 1'b0;
        end else if (count == '0) begin
            count        <= COUNT_WIDTH'(DIVISOR - 1);
            audio_clk_en <= 1'b1;
        end else begin
            count        <= count - 1'b1;
            audio_clk_en <= 1'b0;
        end
    end

endmodule

// ==== source/rc_low_pass_filter.sv ====
/*
 * RC low-pass stage.
 * Series resistor into a grounded capacitor, output is the capacitor voltage.
 * The first-order update runs OVERSAMPLE times per audio sample.
 */
`timescale 1ns/100ps

module rc_low_pass_filter #(
    parameter int SAMPLE_RATE = 48000,
    parameter int OVERSAMPLE  = 8,
    parameter int R           = 47000,
    parameter int C_PF        = 47000
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        audio_clk_en,
    input  discrete_audio_pkg::sample_t sample_in,
    output discrete_audio_pkg::sample_t filtered
);

    import discrete_audio_pkg::*;

    localparam coef_t ALPHA      = rc_alpha(R, C_PF, SAMPLE_RATE, OVERSAMPLE);
    localparam int    STEP_WIDTH = $clog2(OVERSAMPLE + 1);
    // 17-bit difference times 18-bit signed coefficient
    localparam int    PROD_WIDTH = SAMPLE_WIDTH + COEF_FRAC_BITS + 3;

    filter_state_t                 state;
    logic [STEP_WIDTH-1:0]         step_count;
    sample_t                       y;
    sample_t                       x_hold;
    logic signed [SAMPLE_WIDTH:0]  diff;
    logic signed [PROD_WIDTH-1:0]  product;
    logic signed [PROD_WIDTH-1:0]  y_sum;
    sample_t                       y_next;

    // y += alpha * (x - y)
    always_comb begin
        diff    = x_hold - y;
        product = $signed({1'b0, ALPHA}) * diff;
        y_sum   = y + (product >>> COEF_FRAC_BITS);
        // alpha <= 1 keeps the result between y and x, no clamp needed
        y_next  = sample_t'(y_sum);
    end

    // sequencer: publish the state on the strobe, then run the sub-steps
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= FILTER_IDLE;
            step_count <= '0;
            y          <= '0;
            filtered   <= '0;
        end else if (audio_clk_en) begin
            filtered   <= y;
            state      <= FILTER_STEP;
            step_count <= '0;
        end else if (state == FILTER_STEP) begin
            y          <= y_next;
            step_count <= step_count + 1'b1;
            if (step_count == STEP_WIDTH'(OVERSAMPLE - 1)) begin
                state <= FILTER_IDLE;
            end
        end
    end

    // input held for the whole sample period
    always_ff @(posedge clk) begin
        if (audio_clk_en) begin
            x_hold <= sample_in;
        end
    end

endmodule

// ==== source/rc_high_pass_filter.sv ====
/*
 * RC high-pass stage.
 * Series coupling capacitor with a resistor to ground.
 * The first-order update runs OVERSAMPLE times per audio sample and
 * saturates to the sample range.
 */
`timescale 1ns/100ps

module rc_high_pass_filter #(
    parameter int SAMPLE_RATE = 48000,
    parameter int OVERSAMPLE  = 8,
    parameter int R           = 10000,
    parameter int C_PF        = 100000
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        audio_clk_en,
    input  discrete_audio_pkg::sample_t sample_in,
    output discrete_audio_pkg::sample_t filtered
);

    import discrete_audio_pkg::*;

    localparam coef_t BETA =
        coef_t'((1 << COEF_FRAC_BITS) - rc_alpha(R, C_PF, SAMPLE_RATE, OVERSAMPLE));
    localparam int STEP_WIDTH = $clog2(OVERSAMPLE + 1);
    // y + x - x_prev needs two guard bits
    localparam int SUM_WIDTH  = SAMPLE_WIDTH + 2;
    localparam int PROD_WIDTH = SUM_WIDTH + COEF_FRAC_BITS + 2;

    filter_state_t                 state;
    logic [STEP_WIDTH-1:0]         step_count;
    sample_t                       y;
    sample_t                       x_hold;
    sample_t                       x_prev;
    logic signed [SUM_WIDTH-1:0]   delta_sum;
    logic signed [PROD_WIDTH-1:0]  product;
    logic signed [PROD_WIDTH-1:0]  scaled;
    sample_t                       y_next;

    // y = beta * (y + x - x_prev)
    always_comb begin
        delta_sum = y + x_hold - x_prev;
        product   = $signed({1'b0, BETA}) * delta_sum;
        scaled    = product >>> COEF_FRAC_BITS;
        y_next    = saturate_sample(scaled);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= FILTER_IDLE;
            step_count <= '0;
            y          <= '0;
            x_prev     <= '0;
            filtered   <= '0;
        end else if (audio_clk_en) begin
            filtered   <= y;
            state      <= FILTER_STEP;
            step_count <= '0;
        end else if (state == FILTER_STEP) begin
            y          <= y_next;
            // only the first sub-step of a sample sees an input edge
            x_prev     <= x_hold;
            step_count <= step_count + 1'b1;
            if (step_count == STEP_WIDTH'(OVERSAMPLE - 1)) begin
                state <= FILTER_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (audio_clk_en) begin
            x_hold <= sample_in;
        end
    end

endmodule

// ==== source/audio_mixer.sv ====
/*
 * Saturating two-input audio mixer.
 * Weights the low-pass and high-pass samples by Q8 gains, sums,
 * clamps to 16 bits and registers the result with a valid pulse.
 */
`timescale 1ns/100ps

module audio_mixer #(
    parameter int LP_GAIN = 192,
    parameter int HP_GAIN = 128
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        audio_clk_en,
    input  discrete_audio_pkg::sample_t lp_sample,
    input  discrete_audio_pkg::sample_t hp_sample,
    output discrete_audio_pkg::sample_t audio_out,
    output logic                        audio_valid
);

    import discrete_audio_pkg::*;

    localparam int GAIN_WIDTH = SAMPLE_WIDTH + 1;
    localparam int ACC_WIDTH  = SAMPLE_WIDTH + GAIN_WIDTH + 1;

    localparam logic signed [GAIN_WIDTH-1:0] LP_GAIN_S = GAIN_WIDTH'(LP_GAIN);
    localparam logic signed [GAIN_WIDTH-1:0] HP_GAIN_S = GAIN_WIDTH'(HP_GAIN);

    logic                        strobe_d;
    logic signed [ACC_WIDTH-1:0] acc;
    logic signed [ACC_WIDTH-1:0] scaled;

    always_comb begin
        acc    = lp_sample * LP_GAIN_S + hp_sample * HP_GAIN_S;
        scaled = acc >>> GAIN_FRAC_BITS;
    end

    // filter outputs change on the strobe edge, so sample them one clock later
    always_ff @(posedge clk) begin
        if (reset) begin
            strobe_d    <= 1'b0;
            audio_valid <= 1'b0;
            audio_out   <= '0;
        end else begin
            strobe_d    <= audio_clk_en;
            audio_valid <= strobe_d;
            if (strobe_d) begin
                audio_out <= saturate_sample(scaled);
            end
        end
    end

endmodule

// ==== source/discrete_audio_top.sv ====
/*
 * Discrete audio board top level.
 * Voice a through an RC low-pass, voice b through an RC high-pass,
 * both mixed into one sample per audio sample period.
 */
`timescale 1ns/100ps

module discrete_audio_top #(
    parameter int CLOCK_RATE  = 50000000,
    parameter int SAMPLE_RATE = 48000,
    parameter int OVERSAMPLE  = 8,
    parameter int LP_R        = 47000,
    parameter int LP_C_PF     = 47000,
    parameter int HP_R        = 10000,
    parameter int HP_C_PF     = 100000,
    parameter int LP_GAIN     = 192,
    parameter int HP_GAIN     = 128
) (
    input  logic                        clk,
    input  logic                        reset,
    input  discrete_audio_pkg::sample_t voice_a,
    input  discrete_audio_pkg::sample_t voice_b,
    output discrete_audio_pkg::sample_t audio_out,
    output logic                        audio_valid
);

    import discrete_audio_pkg::*;

    logic    audio_clk_en;
    sample_t lp_filtered;
    sample_t hp_filtered;

    // board-wide audio sample clock
    sample_rate_enable #(
        .CLOCK_RATE  (CLOCK_RATE),
        .SAMPLE_RATE (SAMPLE_RATE)
    ) u_rate_enable (
        .clk          (clk),
        .reset        (reset),
        .audio_clk_en (audio_clk_en)
    );

    rc_low_pass_filter #(
        .SAMPLE_RATE (SAMPLE_RATE),
        .OVERSAMPLE  (OVERSAMPLE),
        .R           (LP_R),
        .C_PF        (LP_C_PF)
    ) u_lp_filter (
        .clk          (clk),
        .reset        (reset),
        .audio_clk_en (audio_clk_en),
        .sample_in    (voice_a),
        .filtered     (lp_filtered)
    );

    rc_high_pass_filter #(
        .SAMPLE_RATE (SAMPLE_RATE),
        .OVERSAMPLE  (OVERSAMPLE),
        .R           (HP_R),
        .C_PF        (HP_C_PF)
    ) u_hp_filter (
        .clk          (clk),
        .reset        (reset),
        .audio_clk_en (audio_clk_en),
        .sample_in    (voice_b),
        .filtered     (hp_filtered)
    );

    audio_mixer #(
        .LP_GAIN (LP_GAIN),
        .HP_GAIN (HP_GAIN)
    ) u_mixer (
        .clk          (clk),
        .reset        (reset),
        .audio_clk_en (audio_clk_en),
        .lp_sample    (lp_filtered),
        .hp_sample    (hp_filtered),
        .audio_out    (audio_out),
        .audio_valid  (audio_valid)
    );

endmodule

// ==== sim/tb_clock_gen.sv ====
/*
 * Testbench clock and reset source.
 * Free-running clock and a synchronous reset held for a few cycles.
 */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== sim/discrete_audio_checker.sv ====
/*
 * Discrete audio reference checker.
 * Models both RC stages and the mixer, compares every output sample,
 * the valid pulse spacing and the settled value at the end of each row.
 */
`timescale 1ns/100ps

module discrete_audio_checker #(
    parameter int CLOCK_RATE  = 768000,
    parameter int SAMPLE_RATE = 48000,
    parameter int OVERSAMPLE  = 4,
    parameter int LP_R        = 47000,
    parameter int LP_C_PF     = 47000,
    parameter int HP_R        = 10000,
    parameter int HP_C_PF     = 100000,
    parameter int LP_GAIN     = 192,
    parameter int HP_GAIN     = 128
) (
    input logic                        clk,
    input logic                        reset,
    input discrete_audio_pkg::sample_t voice_a,
    input discrete_audio_pkg::sample_t voice_b,
    input discrete_audio_pkg::sample_t audio_out,
    input logic                        audio_valid
);

    import discrete_audio_pkg::*;

    localparam int     DIVISOR   = CLOCK_RATE / SAMPLE_RATE;
    // strobe register, filter output register, mixer register
    localparam int     FIRST_GAP = DIVISOR + 3;
    localparam int     TOLERANCE = 4;
    localparam longint ALPHA     = rc_alpha(LP_R, LP_C_PF, SAMPLE_RATE, OVERSAMPLE);
    localparam longint BETA      =
        (longint'(1) <<< COEF_FRAC_BITS) - rc_alpha(HP_R, HP_C_PF, SAMPLE_RATE, OVERSAMPLE);

    longint lp_y;
    longint hp_y;
    longint hp_xprev;
    longint model_out;
    int     since_last;
    int     expected_gap;
    bit     seen_first;
    int     sample_errors = 0;
    int     settle_errors = 0;
    int     period_errors = 0;

    function automatic longint limit_sample(input longint value);
        if (value > 32767) begin
            return 32767;
        end else if (value < -32768) begin
            return -32768;
        end
        return value;
    endfunction

    // one audio sample worth of sub-steps on both stages
    task automatic advance_model(input longint xa, input longint xb);
        repeat (OVERSAMPLE) begin
            lp_y     = lp_y + ((ALPHA * (xa - lp_y)) >>> COEF_FRAC_BITS);
            hp_y     = limit_sample((BETA * (hp_y + xb - hp_xprev)) >>> COEF_FRAC_BITS);
            hp_xprev = xb;
        end
    endtask

    task automatic check_settled(input int row, input longint expected);
        longint diff;
        diff = longint'(audio_out) - expected;
        if (diff > TOLERANCE || diff < -TOLERANCE) begin
            $display("Error at %0t: audio_out settled value of row %0d expected %0d got %0d",
                     $time, row, expected, audio_out);
            settle_errors++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            lp_y       = 0;
            hp_y       = 0;
            hp_xprev   = 0;
            since_last = 0;
            seen_first = 1'b0;
        end else begin
            since_last++;
            if (!seen_first && !audio_valid && audio_out !== '0) begin
                $display("Error at %0t: audio_out before first sample expected 0 got %0d",
                         $time, audio_out);
                sample_errors++;
            end
            if (audio_valid) begin
                expected_gap = seen_first ? DIVISOR : FIRST_GAP;
                if (since_last != expected_gap) begin
                    $display("Error at %0t: audio_valid period expected %0d got %0d",
                             $time, expected_gap, since_last);
                    period_errors++;
                end
                model_out = limit_sample((lp_y * LP_GAIN + hp_y * HP_GAIN) >>> GAIN_FRAC_BITS);
                if (audio_out !== sample_t'(model_out)) begin
                    $display("Error at %0t: audio_out expected %0d got %0d",
                             $time, model_out, audio_out);
                    sample_errors++;
                end
                // inputs are still the ones latched at the strobe
                advance_model(voice_a, voice_b);
                since_last = 0;
                seen_first = 1'b1;
            end
        end
    end

endmodule

// ==== sim/discrete_audio_assert.sv ====
/*
 * Strobe and valid timing assertions for the discrete audio top level.
 */
`timescale 1ns/100ps

module discrete_audio_assert (
    input logic                               clk,
    input logic                               reset,
    input logic                               audio_clk_en,
    input logic                               audio_valid,
    input discrete_audio_pkg::filter_state_t  lp_state,
    input discrete_audio_pkg::filter_state_t  hp_state
);

    import discrete_audio_pkg::*;

    int error_count = 0;

    valid_one_wide: assert property (@(posedge clk) disable iff (reset)
        audio_valid |=> !audio_valid)
    else begin
        $error("audio_valid high on two consecutive clocks");
        error_count++;
    end

    // filter register then mixer register
    valid_follows_strobe: assert property (@(posedge clk) disable iff (reset)
        audio_clk_en |-> ##2 audio_valid)
    else begin
        $error("audio_valid missing after the sample strobe");
        error_count++;
    end

    valid_has_strobe: assert property (@(posedge clk) disable iff (reset)
        audio_valid |-> $past(audio_clk_en, 2))
    else begin
        $error("audio_valid without a preceding sample strobe");
        error_count++;
    end

    filters_idle_at_strobe: assert property (@(posedge clk) disable iff (reset)
        audio_clk_en |-> (lp_state == FILTER_IDLE && hp_state == FILTER_IDLE))
    else begin
        $error("filter still running sub-steps when the sample strobe arrived");
        error_count++;
    end

endmodule

bind discrete_audio_top discrete_audio_assert u_timing_assert (
    .clk          (clk),
    .reset        (reset),
    .audio_clk_en (audio_clk_en),
    .audio_valid  (audio_valid),
    .lp_state     (u_lp_filter.state),
    .hp_state     (u_hp_filter.state)
);

// ==== sim/discrete_audio_tb.sv ====
/*
 * Discrete audio board testbench.
 * Applies a table of held voice pairs, checks each row's settled output
 * and runs the cycle timeout.
 */
`timescale 1ns/100ps

module discrete_audio_tb;

    import discrete_audio_pkg::*;

    localparam int CLOCK_RATE  = 768000;
    localparam int SAMPLE_RATE = 48000;
    localparam int OVERSAMPLE  = 4;
    localparam int DIVISOR     = CLOCK_RATE / SAMPLE_RATE;
    localparam int LP_R        = 47000;
    localparam int LP_C_PF     = 47000;
    localparam int HP_R        = 10000;
    localparam int HP_C_PF     = 100000;
    localparam int LP_GAIN     = 192;
    localparam int HP_GAIN     = 128;
    localparam int NUM_ROWS    = 13;
    localparam int NUM_FIXED   = 9;
    localparam int LONG_HOLD   = 800;

    localparam longint LP_ALPHA = rc_alpha(LP_R, LP_C_PF, SAMPLE_RATE, OVERSAMPLE);
    localparam longint HP_BETA  =
        (longint'(1) <<< COEF_FRAC_BITS) - rc_alpha(HP_R, HP_C_PF, SAMPLE_RATE, OVERSAMPLE);

    logic    clk;
    logic    reset;
    logic    audio_valid;
    sample_t voice_a;
    sample_t voice_b;
    sample_t audio_out;

    sample_t row_a[NUM_ROWS];
    sample_t row_b[NUM_ROWS];
    int      row_hold[NUM_ROWS];
    longint  row_expect[NUM_ROWS];
    int      seed;
    int      cycle_count = 0;
    int      timeout_limit = 0;
    int      timeout_errors = 0;

    tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(3)) u_clock (.clk(clk), .reset(reset));

    discrete_audio_top #(
        .CLOCK_RATE (CLOCK_RATE), .SAMPLE_RATE (SAMPLE_RATE), .OVERSAMPLE (OVERSAMPLE),
        .LP_R (LP_R), .LP_C_PF (LP_C_PF), .HP_R (HP_R), .HP_C_PF (HP_C_PF),
        .LP_GAIN (LP_GAIN), .HP_GAIN (HP_GAIN)
    ) dut (
        .clk (clk), .reset (reset), .voice_a (voice_a), .voice_b (voice_b),
        .audio_out (audio_out), .audio_valid (audio_valid)
    );

    discrete_audio_checker #(
        .CLOCK_RATE (CLOCK_RATE), .SAMPLE_RATE (SAMPLE_RATE), .OVERSAMPLE (OVERSAMPLE),
        .LP_R (LP_R), .LP_C_PF (LP_C_PF), .HP_R (HP_R), .HP_C_PF (HP_C_PF),
        .LP_GAIN (LP_GAIN), .HP_GAIN (HP_GAIN)
    ) u_checker (
        .clk (clk), .reset (reset), .voice_a (voice_a), .voice_b (voice_b),
        .audio_out (audio_out), .audio_valid (audio_valid)
    );

    function automatic longint clamp_to_sample(input longint value);
        if (value > 32767) begin
            return 32767;
        end else if (value < -32768) begin
            return -32768;
        end
        return value;
    endfunction

    // the integer update has a dead band, so a rising input is not reached exactly
    function automatic longint low_pass_rest(input longint y, input longint x);
        longint step;
        int     guard;
        guard = 0;
        step  = (LP_ALPHA * (x - y)) >>> COEF_FRAC_BITS;
        while (step != 0 && guard < 100000) begin
            y     = y + step;
            step  = (LP_ALPHA * (x - y)) >>> COEF_FRAC_BITS;
            guard++;
        end
        return y;
    endfunction

    // input edge on the first sub-step, then free decay until it stalls
    function automatic longint high_pass_rest(input longint y, input longint x_prev,
                                              input longint x);
        longint next_y;
        int     guard;
        guard  = 0;
        y      = clamp_to_sample((HP_BETA * (y + x - x_prev)) >>> COEF_FRAC_BITS);
        next_y = (HP_BETA * y) >>> COEF_FRAC_BITS;
        while (next_y != y && guard < 100000) begin
            y      = next_y;
            next_y = (HP_BETA * y) >>> COEF_FRAC_BITS;
            guard++;
        end
        return y;
    endfunction

    task automatic set_row(input int idx, input sample_t a, input sample_t b, input int hold);
        row_a[idx]    = a;
        row_b[idx]    = b;
        row_hold[idx] = hold;
    endtask

    task automatic fill_table();
        longint lp;
        longint hp;
        longint x_prev;
        lp     = 0;
        hp     = 0;
        x_prev = 0;
        set_row(0, 16'sd0, 16'sd0, 40);
        set_row(1, 16'sd8000, 16'sd0, LONG_HOLD);
        set_row(2, 16'sd0, 16'sd0, LONG_HOLD);
        set_row(3, 16'sd0, 16'sd12000, LONG_HOLD);
        set_row(4, 16'sd0, 16'sd0, LONG_HOLD);
        set_row(5, 16'sd32767, -16'sd32768, LONG_HOLD);
        set_row(6, 16'sd32767, 16'sd32767, LONG_HOLD);
        set_row(7, -16'sd32768, 16'sd32767, LONG_HOLD);
        set_row(8, -16'sd32768, -16'sd32768, LONG_HOLD);
        for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
            set_row(i, sample_t'($random(seed)), sample_t'($random(seed)), LONG_HOLD);
        end
        // each row starts from where the previous one came to rest
        for (int i = 0; i < NUM_ROWS; i++) begin
            lp     = low_pass_rest(lp, row_a[i]);
            hp     = high_pass_rest(hp, x_prev, row_b[i]);
            x_prev = row_b[i];
            row_expect[i] = clamp_to_sample((lp * LP_GAIN + hp * HP_GAIN) >>> GAIN_FRAC_BITS);
        end
    endtask

    task automatic wait_valid_pulses(input int count);
        repeat (count) begin
            @(negedge clk);
            while (audio_valid !== 1'b1) @(negedge clk);
        end
    endtask

    task automatic report_result(input bit timed_out);
        int total;
        total = u_checker.sample_errors + u_checker.settle_errors + u_checker.period_errors
              + dut.u_timing_assert.error_count + timeout_errors;
        $display("errors: sample %0d, settled %0d, period %0d, assertion %0d, timeout %0d",
                 u_checker.sample_errors, u_checker.settle_errors, u_checker.period_errors,
                 dut.u_timing_assert.error_count, timeout_errors);
        if (total == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (timeout_limit > 0 && cycle_count > timeout_limit) begin
            $display("Timeout: audio_valid pulses stopped arriving after %0d cycles",
                     cycle_count);
            timeout_errors++;
            report_result(1'b1);
        end
    end

    initial begin
        int total_hold;
        seed       = 32'h1b23_a030;
        total_hold = 0;
        voice_a    = '0;
        voice_b    = '0;
        fill_table();
        for (int i = 0; i < NUM_ROWS; i++) begin
            total_hold += row_hold[i];
        end
        timeout_limit = total_hold * DIVISOR + 200;
        voice_a = row_a[0];
        voice_b = row_b[0];
        for (int r = 0; r < NUM_ROWS; r++) begin
            wait_valid_pulses(row_hold[r]);
            u_checker.check_settled(r, row_expect[r]);
            // one clock clear of the valid pulse, far from the next strobe
            @(negedge clk);
            if (r < NUM_ROWS - 1) begin
                voice_a = row_a[r + 1];
                voice_b = row_b[r + 1];
            end
        end
        report_result(1'b0);
    end

endmodule

// ==== discrete_audio_top.f ====
source/discrete_audio_pkg.sv
source/sample_rate_enable.sv
source/rc_low_pass_filter.sv
source/rc_high_pass_filter.sv
source/audio_mixer.sv
source/discrete_audio_top.sv
sim/tb_clock_gen.sv
sim/discrete_audio_checker.sv
sim/discrete_audio_assert.sv
sim/discrete_audio_tb.sv
